// File: tb.f
rtl/deflate_format_pkg.sv
rtl/stream_pkg.sv
rtl/stored_block_ctrl.sv
rtl/crc32_engine.sv
rtl/byte_packer.sv
rtl/stored_deflate_top.sv
testbench/stored_deflate_properties.sv
testbench/stored_deflate_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module stored_deflate_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vstored_deflate_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "All checks passed"; then
	exit 0
fi
echo "Simulation did not report success"
exit 1

// File: testbench/stored_deflate_tb.sv
// Testbench for the stored deflate encoder with its gzip trailer
// Streams are built from the block table and every output word is checked against a reference
// Data bytes, stalls and input gaps come from one LFSR, so each run repeats exactly

`timescale 1ns/1ns

module stored_deflate_tb;

	// One block of a stream, the stream ends at the first entry with bfinal set
	typedef struct packed {
		deflate_format_pkg::block_len_t len;
		logic                           bfinal;
		logic                           stress; // Random out_ready stalls and in_valid gaps
	} block_entry_t;

	// ====================
	// Stimulus table
	// ====================
	localparam int NUM_BLOCKS = 11;
	localparam block_entry_t BLOCKS [NUM_BLOCKS] = '{
		'{16'd10, 1'b1, 1'b0}, // Single final block
		'{16'd5,  1'b0, 1'b0}, // Three blocks, 48 output bytes so the last word is all zero
		'{16'd7,  1'b0, 1'b0},
		'{16'd13, 1'b1, 1'b0},
		'{16'd0,  1'b0, 1'b0}, // Empty block followed by a normal one
		'{16'd6,  1'b1, 1'b0},
		'{16'd9,  1'b0, 1'b1}, // From here on under back-pressure
		'{16'd23, 1'b1, 1'b1},
		'{16'd1,  1'b1, 1'b1},
		'{16'd0,  1'b1, 1'b1}, // Empty final block, CRC of nothing is zero
		'{16'd37, 1'b1, 1'b1}
	};

	logic              clk;
	logic              rst_n;
	stream_pkg::word_t in_data;
	logic              in_valid;
	logic              in_ready;
	stream_pkg::word_t out_data;
	logic              out_valid;
	logic              out_last;
	logic              out_ready;

	logic [31:0]       lfsr_q = 32'h76ea;
	stream_pkg::word_t in_q[$];       // Input words of the current stream
	logic [7:0]        exp_byte_q[$]; // Expected output bytes in stream order
	stream_pkg::word_t exp_word_q[$];
	logic              exp_last_q[$];

	stored_deflate_top stored_deflate_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_ready (out_ready)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit, the newest bit lands in bit 0
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[6:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Reference CRC32, one input bit at a time with the feedback taken before the shift
	function automatic deflate_format_pkg::crc_t crc_step(input deflate_format_pkg::crc_t c_in,
	                                                      input logic [7:0] b);
		deflate_format_pkg::crc_t c;
		logic                     fb;
		c = c_in;
		for (int i = 0; i < 8; i++) begin
			fb = c[0] ^ b[i];
			c  = c >> 1;
			if (fb)
				c = c ^ 32'hEDB8_8320;
		end
		return c;
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input stream_pkg::word_t got, input stream_pkg::word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: output word %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_last(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: out_last %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	// ====================
	// Reference model
	// ====================
	// Fills in_q and the expected words for the stream starting at table entry idx
	task automatic build_stream(inout int idx, output logic stress);
		block_entry_t                      e;
		deflate_format_pkg::block_header_u hdr;
		deflate_format_pkg::crc_t          crc_acc;
		deflate_format_pkg::crc_t          isize;
		stream_pkg::word_t                 w;
		int                                nbytes;
		crc_acc = 32'hFFFF_FFFF;
		isize   = '0;
		stress  = 1'b0;
		exp_byte_q.delete();
		do begin
			e = BLOCKS[idx];
			idx++;
			stress = stress | e.stress;
			hdr.raw           = '0;
			hdr.fields.len    = e.len;
			hdr.fields.bfinal = e.bfinal;
			in_q.push_back(hdr.raw);
			exp_byte_q.push_back({7'b0, e.bfinal}); // BFINAL in bit 0, BTYPE 00, pad zero
			exp_byte_q.push_back(e.len[7:0]);
			exp_byte_q.push_back(e.len[15:8]);
			exp_byte_q.push_back(~e.len[7:0]);      // NLEN
			exp_byte_q.push_back(~e.len[15:8]);
			isize = isize + {16'b0, e.len};
			for (int i = 0; i < int'(e.len); i += 4) begin
				for (int j = 0; j < 4; j++) begin
					w[j*8 +: 8] = take_bits(8); // Unused lanes of a last word stay random
					if (i + j < int'(e.len)) begin
						exp_byte_q.push_back(w[j*8 +: 8]);
						crc_acc = crc_step(crc_acc, w[j*8 +: 8]);
					end
				end
				in_q.push_back(w);
			end
		end while (!e.bfinal);
		crc_acc = ~crc_acc;
		for (int k = 0; k < 4; k++)
			exp_byte_q.push_back(crc_acc[k*8 +: 8]);
		for (int k = 0; k < 4; k++)
			exp_byte_q.push_back(isize[k*8 +: 8]);
		// Always bytes/4 + 1 words, so a full last word is followed by a zero word
		nbytes = exp_byte_q.size();
		for (int b = 0; b <= nbytes; b += 4) begin
			for (int j = 0; j < 4; j++)
				w[j*8 +: 8] = (b + j < nbytes) ? exp_byte_q[b + j] : 8'h00;
			exp_word_q.push_back(w);
			exp_last_q.push_back(b + 4 > nbytes);
		end
	endtask

	// ====================
	// Stream driver and monitor
	// ====================
	task automatic run_stream(input logic stress);
		int   cycles;
		logic in_taken;
		cycles   = 0;
		in_taken = 1'b0;
		while (in_q.size() > 0 || exp_word_q.size() > 0) begin
			@(negedge clk);
			if (in_taken)
				in_valid = 1'b0; // Held word went at the last rising edge
			if (!in_valid && in_q.size() > 0 && (!stress || take_bits(1) == 8'h01)) begin
				in_data  = in_q.pop_front();
				in_valid = 1'b1;
			end
			out_ready = !stress || (take_bits(1) == 8'h01);
			#1;
			// Both sides have settled, these transfers happen at the next rising edge
			in_taken = in_valid && in_ready;
			if (out_valid && out_ready) begin
				if (exp_word_q.size() == 0) begin
					$display("An output word arrived at %0t ns when none was expected", $time);
					abort_run();
				end
				check_word(out_data, exp_word_q.pop_front());
				check_last(out_last, exp_last_q.pop_front());
			end
			cycles++;
			if (cycles > 4000) begin
				$display("Timeout: the stream did not complete within 4000 cycles");
				abort_run();
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int   idx;
		logic stress;
		rst_n     = 1'b0;
		in_data   = '0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		for (int i = 0; i < 8; i++)
			@(negedge clk);
		rst_n = 1'b1;
		idx   = 0;
		while (idx < NUM_BLOCKS) begin
			build_stream(idx, stress); // Each stream starts with a fresh CRC and ISIZE
			run_stream(stress);
		end
		// Nothing more may come out once every stream is done
		out_ready = 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			if (out_valid) begin
				$display("The encoder produced an extra output word after the last stream");
				abort_run();
			end
		end
		$display("All checks passed");
		$finish;
	end

endmodule

// File: testbench/stored_deflate_properties.sv
// Handshake assertions bound into every byte_packer instance
// All checks are off while rst_n is low

`timescale 1ns/1ns

module stored_deflate_properties (
	input logic                  clk,
	input logic                  rst_n,
	input stream_pkg::byte_cnt_t chunk_bytes,
	input logic                  chunk_valid,
	input stream_pkg::word_t     out_data,
	input logic                  out_valid,
	input logic                  out_last,
	input logic                  out_ready
);

	// A stalled output word neither changes nor disappears
	out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
		else $error("out_data or out_valid changed while out_ready was low");

	// A stalled word keeps its last flag until it is taken
	out_last_a: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> $stable(out_last))
		else $error("out_last changed while out_ready was low");

	// Chunks carry one to four bytes, never zero
	chunk_size_a: assert property (@(posedge clk) disable iff (!rst_n)
		chunk_valid |-> (chunk_bytes >= 3'd1 && chunk_bytes <= 3'd4))
		else $error("chunk_bytes out of range 1 to 4");

endmodule

bind byte_packer stored_deflate_properties packer_props_inst (
	.clk         (clk),
	.rst_n       (rst_n),
	.chunk_bytes (chunk_bytes),
	.chunk_valid (chunk_valid),
	.out_data    (out_data),
	.out_valid   (out_valid),
	.out_last    (out_last),
	.out_ready   (out_ready)
);

// File: rtl/stored_deflate_top.sv
// Stored-mode deflate encoder with a gzip CRC32/ISIZE trailer
// Input is one header word per block followed by LEN bytes, four per word
// Output words are packed lowest byte first and the stream's last word has out_last
// Both sides use valid/ready and in_ready can depend on out_ready in the same cycle

`timescale 1ns/1ns

module stored_deflate_top (
	input  logic              clk,
	input  logic              rst_n,
	input  stream_pkg::word_t in_data,
	input  logic              in_valid,
	output logic              in_ready,
	output stream_pkg::word_t out_data,
	output logic              out_valid,
	output logic              out_last,
	input  logic              out_ready
);

	// ====================
	// Controller to packer
	// ====================
	stream_pkg::word_t        chunk_data;
	stream_pkg::byte_cnt_t    chunk_bytes;
	logic                     chunk_last;
	logic                     chunk_valid;
	logic                     chunk_ready;

	// ====================
	// Controller to CRC
	// ====================
	stream_pkg::word_t        crc_data;
	stream_pkg::byte_cnt_t    crc_bytes;
	logic                     crc_update;
	logic                     crc_clear;
	deflate_format_pkg::crc_t crc;

	stored_block_ctrl ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_data     (in_data),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.chunk_data  (chunk_data),
		.chunk_bytes (chunk_bytes),
		.chunk_last  (chunk_last),
		.chunk_valid (chunk_valid),
		.chunk_ready (chunk_ready),
		.crc_data    (crc_data),
		.crc_bytes   (crc_bytes),
		.crc_update  (crc_update),
		.crc_clear   (crc_clear),
		.crc         (crc)
	);

	// Registers each update on the same edge as the data chunk transfer
	crc32_engine crc_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.crc_data   (crc_data),
		.crc_bytes  (crc_bytes),
		.crc_update (crc_update),
		.crc_clear  (crc_clear),
		.crc        (crc)
	);

	byte_packer packer_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.chunk_data  (chunk_data),
		.chunk_bytes (chunk_bytes),
		.chunk_last  (chunk_last),
		.chunk_valid (chunk_valid),
		.chunk_ready (chunk_ready),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_last    (out_last),
		.out_ready   (out_ready)
	);

endmodule

// File: rtl/byte_packer.sv
// Packs chunks of 1 to 4 bytes into 32-bit words, lowest byte first
// An eight-byte store is enough because a chunk is only taken when it fits after the pop
// chunk_last flushes the store and the final word is zero-filled and marked out_last
// While a flush is pending no new chunk is accepted

`timescale 1ns/1ns

module byte_packer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  stream_pkg::word_t     chunk_data,
	input  stream_pkg::byte_cnt_t chunk_bytes,
	input  logic                  chunk_last,
	input  logic                  chunk_valid,
	output logic                  chunk_ready,
	output stream_pkg::word_t     out_data,
	output logic                  out_valid,
	output logic                  out_last,
	input  logic                  out_ready
);

	logic [63:0] store_q;   // Byte 0 is the oldest byte
	logic [63:0] store_pop; // Store after this cycle's output word left
	logic [63:0] store_d;
	logic [63:0] chunk_ext; // Chunk moved up to sit above the remaining fill
	logic [3:0]  fill_q;    // Valid bytes in the store, 0 to 8
	logic [3:0]  fill_pop;
	logic [3:0]  fill_d;
	logic [3:0]  pop_cnt;   // Bytes leaving with the output word
	logic [7:0]  lane_en;   // Store bytes written by the incoming chunk
	logic        flush_q;   // ISIZE was taken and the tail is still draining
	logic        out_fire;
	logic        chunk_fire;

	// Lane mask for the lowest n bytes of a chunk
	function automatic logic [3:0] low_lanes(input stream_pkg::byte_cnt_t n);
		logic [3:0] m;
		case (n)
			3'd1:    m = 4'b0001;
			3'd2:    m = 4'b0011;
			3'd3:    m = 4'b0111;
			3'd4:    m = 4'b1111;
			default: m = 4'b0000;
		endcase
		return m;
	endfunction

	// ====================
	// Output side
	// ====================
	assign out_valid = (fill_q >= 4'd4) || flush_q;
	assign out_last  = flush_q && (fill_q < 4'd4); // Tail of 0 to 3 bytes closes the stream
	assign out_fire  = out_valid && out_ready;

	// Bytes above the fill read as zero
	always_comb begin
		for (int i = 0; i < stream_pkg::WORD_BYTES; i++) begin
			if (fill_q > 4'(i))
				out_data[i*8 +: 8] = store_q[i*8 +: 8];
			else
				out_data[i*8 +: 8] = 8'h00;
		end
	end

	// A full word leaves four bytes, the last word leaves whatever is there
	assign pop_cnt   = !out_fire ? 4'd0 : (fill_q >= 4'd4) ? 4'd4 : fill_q;
	assign fill_pop  = fill_q - pop_cnt;
	assign store_pop = (pop_cnt == 4'd4) ? {32'b0, store_q[63:32]} : store_q;

	// ====================
	// Input side
	// ====================
	// Above four bytes a chunk only fits when a word leaves in the same cycle
	assign chunk_ready = !flush_q && ((fill_q <= 4'd4) || out_ready);
	assign chunk_fire  = chunk_valid && chunk_ready;

	assign chunk_ext = {32'b0, chunk_data} << {fill_pop, 3'b000};
	assign lane_en   = chunk_fire ? ({4'b0, low_lanes(chunk_bytes)} << fill_pop) : 8'b0;

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			if (lane_en[i])
				store_d[i*8 +: 8] = chunk_ext[i*8 +: 8];
			else
				store_d[i*8 +: 8] = store_pop[i*8 +: 8];
		end
	end

	assign fill_d = fill_pop + (chunk_fire ? {1'b0, chunk_bytes} : 4'd0);

	// ====================
	// Registers
	// ====================
	always_ff @(posedge clk) begin
		store_q <= store_d; // Shifted by the output word and filled by the chunk in one step
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fill_q  <= '0;
			flush_q <= 1'b0;
		end else begin
			fill_q <= fill_d;
			if (chunk_fire && chunk_last)
				flush_q <= 1'b1;
			else if (out_fire && out_last)
				flush_q <= 1'b0; // Final word is gone and the next stream may start
		end
	end

endmodule

// File: rtl/crc32_engine.sv
// Running CRC32 (reflected 0xEDB88320) over up to four bytes per cycle
// Lanes are taken lowest first and only the lowest crc_bytes lanes count
// crc_clear and crc_update are never high together

`timescale 1ns/1ns

module crc32_engine (
	input  logic                     clk,
	input  logic                     rst_n,
	input  stream_pkg::word_t        crc_data,
	input  stream_pkg::byte_cnt_t    crc_bytes,
	input  logic                     crc_update,
	input  logic                     crc_clear,
	output deflate_format_pkg::crc_t crc
);

	deflate_format_pkg::crc_t crc_q;    // Running register before the final XOR
	deflate_format_pkg::crc_t crc_next; // Register after the valid lanes

	// One byte of the bitwise reflected CRC
	function automatic deflate_format_pkg::crc_t crc_byte(input deflate_format_pkg::crc_t c_in,
	                                                      input logic [7:0] b);
		deflate_format_pkg::crc_t c;
		c = c_in ^ {24'b0, b};
		for (int k = 0; k < 8; k++) begin
			if (c[0])
				c = (c >> 1) ^ deflate_format_pkg::CRC_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// Four chained byte steps, later lanes skipped past crc_bytes
	always_comb begin
		crc_next = crc_q;
		for (int lane = 0; lane < stream_pkg::WORD_BYTES; lane++) begin
			if (lane < int'(crc_bytes))
				crc_next = crc_byte(crc_next, crc_data[lane*8 +: 8]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crc_q <= deflate_format_pkg::CRC_INIT;
		else if (crc_clear)
			crc_q <= deflate_format_pkg::CRC_INIT; // Next stream starts over
		else if (crc_update)
			crc_q <= crc_next;
	end

	assign crc = crc_q ^ deflate_format_pkg::CRC_INIT; // Final XOR is all ones too

endmodule

// File: rtl/stored_block_ctrl.sv
// Control FSM for stored deflate blocks with a gzip trailer
// A header word must come first and LEN data bytes follow in the next words
// Data words pass through to the packer in the same cycle, so in_ready follows chunk_ready
// Header words are taken without waiting on the packer

`timescale 1ns/1ns

module stored_block_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  stream_pkg::word_t         in_data,
	input  logic                      in_valid,
	output logic                      in_ready,
	output stream_pkg::word_t         chunk_data,
	output stream_pkg::byte_cnt_t     chunk_bytes,
	output logic                      chunk_last,
	output logic                      chunk_valid,
	input  logic                      chunk_ready,
	output stream_pkg::word_t         crc_data,
	output stream_pkg::byte_cnt_t     crc_bytes,
	output logic                      crc_update,
	output logic                      crc_clear,
	input  deflate_format_pkg::crc_t  crc
);

	// ====================
	// State encoding
	// ====================
	localparam logic [2:0] S_WAIT_HDR = 3'd0; // Waiting for a block header word
	localparam logic [2:0] S_HDR_BYTE = 3'd1; // Offering the BFINAL/BTYPE byte
	localparam logic [2:0] S_LENGTH   = 3'd2; // Offering LEN and NLEN
	localparam logic [2:0] S_DATA     = 3'd3; // Passing data words through
	localparam logic [2:0] S_CRC      = 3'd4; // Offering CRC32
	localparam logic [2:0] S_ISIZE    = 3'd5; // Offering ISIZE, marked last

	logic [2:0]                     state_q;
	logic [2:0]                     state_d;
	deflate_format_pkg::block_header_u hdr;
	deflate_format_pkg::block_len_t len_rem_q; // Bytes of the block still to send
	logic                           bfinal_q;
	deflate_format_pkg::crc_t       isize_q;   // Sum of all LEN in this stream
	logic                           hdr_fire;
	logic                           chunk_fire;
	logic                           data_end;   // Current data chunk is the block's last

	assign hdr.raw = in_data; // Decode the incoming word as a header

	assign hdr_fire   = (state_q == S_WAIT_HDR) && in_valid;
	assign chunk_fire = chunk_valid && chunk_ready;

	// At most one word is left, so this chunk closes the block
	assign data_end = (len_rem_q <= deflate_format_pkg::block_len_t'(stream_pkg::WORD_BYTES));

	// ====================
	// Chunk and handshake outputs
	// ====================
	always_comb begin
		in_ready    = 1'b0;
		chunk_valid = 1'b0;
		chunk_last  = 1'b0;
		chunk_data  = '0;
		chunk_bytes = 3'd4;
		state_d     = state_q;
		case (state_q)
			S_WAIT_HDR: begin
				in_ready = 1'b1; // The header never waits on the packer
				if (in_valid)
					state_d = S_HDR_BYTE;
			end
			S_HDR_BYTE: begin
				chunk_valid = 1'b1;
				chunk_bytes = 3'd1;
				chunk_data  = {24'b0, bfinal_q ? deflate_format_pkg::STORED_HEADER_FINAL
				                               : deflate_format_pkg::STORED_HEADER_MORE};
				if (chunk_ready)
					state_d = S_LENGTH;
			end
			S_LENGTH: begin
				// LEN then NLEN, each least significant byte first
				chunk_valid = 1'b1;
				chunk_data  = {~len_rem_q, len_rem_q};
				if (chunk_ready) begin
					if (len_rem_q != '0)
						state_d = S_DATA;
					else if (bfinal_q)
						state_d = S_CRC; // Empty final block goes straight to the trailer
					else
						state_d = S_WAIT_HDR;
				end
			end
			S_DATA: begin
				in_ready    = chunk_ready;
				chunk_valid = in_valid;
				chunk_data  = in_data;
				chunk_bytes = data_end ? len_rem_q[2:0] : 3'd4; // Partial last word
				if (chunk_fire && data_end)
					state_d = bfinal_q ? S_CRC : S_WAIT_HDR;
			end
			S_CRC: begin
				chunk_valid = 1'b1; // CRC register already holds the last data update here
				chunk_data  = crc;
				if (chunk_ready)
					state_d = S_ISIZE;
			end
			S_ISIZE: begin
				chunk_valid = 1'b1;
				chunk_last  = 1'b1; // Tells the packer to flush
				chunk_data  = isize_q;
				if (chunk_ready)
					state_d = S_WAIT_HDR;
			end
			default: state_d = S_WAIT_HDR;
		endcase
	end

	// The CRC sees exactly the data chunks, lane for lane
	assign crc_data   = in_data;
	assign crc_bytes  = chunk_bytes;
	assign crc_update = (state_q == S_DATA) && chunk_fire;
	assign crc_clear  = (state_q == S_ISIZE) && chunk_fire; // Fresh CRC for the next stream

	// ====================
	// Registers
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= S_WAIT_HDR;
			len_rem_q <= '0;
			bfinal_q  <= 1'b0;
			isize_q   <= '0;
		end else begin
			state_q <= state_d;
			if (hdr_fire) begin
				len_rem_q <= hdr.fields.len;
				bfinal_q  <= hdr.fields.bfinal;
				isize_q   <= isize_q + {16'b0, hdr.fields.len}; // Wraps modulo 2^32
			end else if (crc_clear) begin
				isize_q <= '0;
			end
			if (crc_update)
				len_rem_q <= len_rem_q - {13'b0, chunk_bytes};
		end
	end

endmodule

// File: rtl/stream_pkg.sv
// Word and byte lane definitions for the input, chunk and output streams
// Byte lane 0 is bits 7..0 and is always the first byte in stream order

package stream_pkg;

	// ====================
	// Stream words
	// ====================

	typedef logic [31:0] word_t; // One stream word, lowest byte first

	localparam int WORD_BYTES = 4; // Byte lanes per word

	// Number of valid bytes in a chunk, from 1 to 4
	// The valid bytes are always the lowest lanes
	typedef logic [2:0] byte_cnt_t;

endpackage

// File: rtl/deflate_format_pkg.sv
// Stored deflate block and gzip trailer formats
// Only BTYPE 00 is described, so every field sits on a byte boundary
// The header word keeps bits 31..25 and 23..16 reserved and they are ignored

package deflate_format_pkg;

	// ====================
	// Block header word
	// ====================

	// The block header word seen as fields
	typedef struct packed {
		logic [6:0]  rsvd_hi; // Ignored
		logic        bfinal;  // Set on the last block of a stream
		logic [7:0]  rsvd_lo; // Ignored
		logic [15:0] len;     // Number of data bytes that follow
	} block_header_fields_t;

	// One input word that is read either raw or as header fields
	typedef union packed {
		logic [31:0]          raw;
		block_header_fields_t fields;
	} block_header_u;

	typedef logic [15:0] block_len_t; // LEN and NLEN are both this wide

	// ====================
	// gzip trailer
	// ====================

	typedef logic [31:0] crc_t; // Also holds ISIZE

	localparam crc_t CRC_POLY = 32'hEDB88320; // Reflected form of 0x04C11DB7
	localparam crc_t CRC_INIT = 32'hFFFFFFFF; // The final XOR uses the same all ones value

	// First byte of a stored block with BTYPE 00 and the pad bits zero
	localparam logic [7:0] STORED_HEADER_FINAL = 8'h01;
	localparam logic [7:0] STORED_HEADER_MORE  = 8'h00;

endpackage
